// ==== verilog.f ====
verilog/ctrl_cfg_pkg.sv
verilog/ctrl_types_pkg.sv
verilog/cnt_if.sv
verilog/ctrl_counter.sv
verilog/fence_t_fsm.sv
verilog/flush_decode.sv
verilog/flush_ctrl_top.sv
verif/flush_ctrl_properties.sv
verif/flush_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert --top-module flush_ctrl_tb -f verilog.f \
  -o flush_ctrl_sim &&
./obj_dir/flush_ctrl_sim | tee sim.log
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verif/flush_ctrl_tb.sv ====
// Self-checking testbench of flush_ctrl_top with a write-back data cache
// Data cache acknowledge and busy are modeled here, pad values stay below 257

`timescale 1ns/1ps

module flush_ctrl_tb;

  import ctrl_cfg_pkg::*;
  import ctrl_types_pkg::*;

  localparam int Vlen = VlenDefault;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic mispredict_i;
  logic fence_i;
  logic fence_i_i;
  logic sfence_vma_i;
  logic fence_t_i;
  logic flush_csr_i;
  logic ex_valid_i;
  logic eret_i;
  logic halt_csr_i;
  logic time_irq_i;
  priv_lvl_e priv_lvl_i;
  logic pad_src_sel_i;
  logic [PadWidth-1:0] fence_t_pad_i;
  logic [Vlen-1:0] boot_addr_i;
  logic [Vlen-1:0] pc_commit_i;
  // Driven by the cache model only
  logic flush_dcache_ack_i = 1'b0;
  logic cache_busy_i = 1'b0;

  logic set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o;
  logic flush_ex_o, flush_bp_o, flush_icache_o, flush_tlb_o;
  logic flush_dcache_o, halt_o, stall_cache_o, rst_uarch_no, cache_init_no;
  logic [Vlen-1:0] rst_addr_o;
  logic [PadWidth-1:0] fence_t_ceil_o;
  logic [7:0] strobes;

  int n_pass = 0;
  int n_fail = 0;
  logic timed_out = 1'b0;
  logic [31:0] stim_seed = 32'd52022;
  logic [31:0] cache_seed = 32'd52022;

  flush_ctrl_top #(.Vlen(Vlen), .DcacheType(DCACHE_WB)) dut_i (.*);

  // {set_pc, if, unissued, id, ex, bp, icache, tlb}
  assign strobes = {set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o,
                    flush_ex_o, flush_bp_o, flush_icache_o, flush_tlb_o};

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  // --------------------------------------------------------------------
  // Data cache model
  // --------------------------------------------------------------------

  // Phase 0 idle, 1 counting down to the acknowledge, 2 waiting for the drop
  logic [1:0] ack_phase = 2'd0;
  logic [3:0] ack_delay = 4'd0;

  always @(posedge clk_i) begin
    cache_seed = lcg_next(cache_seed);
    // Busy about one cycle in sixteen
    cache_busy_i       <= rst_ni && (cache_seed[31:28] == 4'h0);
    flush_dcache_ack_i <= 1'b0;
    if (!rst_ni) begin
      ack_phase <= 2'd0;
    end else if (ack_phase == 2'd0) begin
      if (flush_dcache_o) begin
        ack_delay <= {1'b0, cache_seed[27:25]} + 4'd1;
        ack_phase <= 2'd1;
      end
    end else if (ack_phase == 2'd1) begin
      if (ack_delay == 4'd1) begin
        flush_dcache_ack_i <= 1'b1;
        ack_phase          <= 2'd2;
      end else begin
        ack_delay <= ack_delay - 4'd1;
      end
    end else if (!flush_dcache_o) begin
      ack_phase <= 2'd0;
    end
  end

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------

  // Pad timer, loaded by the selected source, runs down to zero
  logic [PadWidth-1:0] model_pad;
  logic model_irq_q;
  priv_lvl_e model_priv_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_pad    <= '0;
      model_irq_q  <= 1'b0;
      model_priv_q <= PRIV_LVL_M;
    end else begin
      model_irq_q  <= time_irq_i;
      model_priv_q <= priv_lvl_i;
      if (pad_src_sel_i ? (model_priv_q == PRIV_LVL_U && priv_lvl_i != PRIV_LVL_U)
                        : (time_irq_i && !model_irq_q)) begin
        model_pad <= fence_t_pad_i;
      end else if (model_pad != '0) begin
        model_pad <= model_pad - PadWidth'(1);
      end
    end
  end

  // Event bits {eret, ex, csr, fence.t, sfence, fence.i, fence, mispredict}
  function automatic logic [7:0] expect_strobes(input logic [7:0] ev);
    logic [7:0] s;
    s = 8'h00;
    if (ev[0]) s[6:5] = 2'b11;
    if (ev[1] || ev[2] || ev[3] || ev[5]) s[7:3] = 5'b11111;
    s[1] = ev[2] || ev[4];
    s[0] = ev[3];
    // Exception or eret overrides the commit PC and flushes the predictor
    if (ev[6] || ev[7]) begin
      s[7]   = 1'b0;
      s[6:3] = 4'hf;
      s[2]   = 1'b1;
    end
    return s;
  endfunction

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout at %0t: %s did not happen in time", $time, what);
    timed_out = 1'b1;
    n_fail++;
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (n_fail == fails_before) $display("Test %s: passed", name);
    else $display("Test %s: failed with %0d errors", name, n_fail - fails_before);
  endtask

  task automatic drive_events(input logic [7:0] ev);
    mispredict_i <= ev[0];
    fence_i      <= ev[1];
    fence_i_i    <= ev[2];
    sfence_vma_i <= ev[3];
    fence_t_i    <= ev[4];
    flush_csr_i  <= ev[5];
    ex_valid_i   <= ev[6];
    eret_i       <= ev[7];
  endtask

  // One strobe cycle, checked in the same cycle
  task automatic apply_and_check(input logic [7:0] ev);
    @(posedge clk_i);
    drive_events(ev);
    @(negedge clk_i);
    check("flush strobes", 64'(expect_strobes(ev)), 64'(strobes));
  endtask

  task automatic fence_seq(input logic [7:0] ev);
    logic seen_ack;
    apply_and_check(ev);
    seen_ack = 1'b0;
    for (int c = 0; c < 24 && !seen_ack; c++) begin
      @(posedge clk_i);
      drive_events(8'h00);
      @(negedge clk_i);
      check("flush_dcache_o", 64'(1), 64'(flush_dcache_o));
      check("halt_o", 64'(1), 64'(halt_o));
      seen_ack = flush_dcache_ack_i;
    end
    if (!seen_ack) begin
      note_timeout("data cache acknowledge after fence");
    end else begin
      @(negedge clk_i);
      check("flush_dcache_o", 64'(0), 64'(flush_dcache_o));
      check("halt_o", 64'(0), 64'(halt_o));
    end
  endtask

  // Full fence.t run, pad loaded just before the fence.t strobe
  task automatic fence_t_seq(input logic sel);
    logic [31:0] r;
    logic [Vlen-1:0] pc;
    logic [PadWidth-1:0] pad;
    logic [PadWidth-1:0] exp_ceil;
    logic done;
    int low_cnt;
    int init_cnt;
    int idle_run;
    int phase;
    r   = rand32();
    pad = PadWidth'(r[31:24]) + PadWidth'(1);
    pc  = Vlen'({rand32(), rand32()});
    @(posedge clk_i);
    pad_src_sel_i <= sel;
    fence_t_pad_i <= pad;
    pc_commit_i   <= pc;
    time_irq_i    <= 1'b0;
    priv_lvl_i    <= PRIV_LVL_U;
    // Rising timer interrupt or leaving U mode
    @(posedge clk_i);
    if (sel) priv_lvl_i <= PRIV_LVL_M;
    else time_irq_i <= 1'b1;
    apply_and_check(8'h10);
    done    = 1'b0;
    low_cnt = 0;
    idle_run = 0;
    // Phase 0 dcache flush, 1 drain, 2 past the drain
    phase   = 0;
    for (int c = 0; c < 2000 && !done; c++) begin
      @(posedge clk_i);
      drive_events(8'h00);
      // Toggle the source that is not selected, it must be ignored
      r = rand32();
      if (r[31:29] == 3'd0) begin
        if (sel) time_irq_i <= ~time_irq_i;
        else priv_lvl_i <= (priv_lvl_i == PRIV_LVL_U) ? PRIV_LVL_M : PRIV_LVL_U;
      end
      @(negedge clk_i);
      if (!stall_cache_o) begin
        done = 1'b1;
      end else begin
        check("halt_o", 64'(1), 64'(halt_o));
        if (!rst_uarch_no) begin
          low_cnt++;
          check("cache_init_no", 64'(1), 64'(cache_init_no));
        end
        exp_ceil = '0;
        if (phase == 1) begin
          idle_run = cache_busy_i ? 0 : idle_run + 1;
          if (idle_run == DrainCycles) begin
            phase    = 2;
            exp_ceil = (model_pad == '0) ? '0 : pad - model_pad;
          end
        end
        check("fence_t_ceil_o", 64'(exp_ceil), 64'(fence_t_ceil_o));
        if (phase == 0 && flush_dcache_ack_i) phase = 1;
      end
    end
    if (!done) begin
      note_timeout("end of the fence.t sequence");
    end else begin
      check("drain phase reached", 64'(2), 64'(phase));
      check("rst_uarch_no low cycles", 64'(RstUarchCycles), 64'(low_cnt));
      check("rst_addr_o", 64'(pc + Vlen'(4)), 64'(rst_addr_o));
      init_cnt = 0;
      for (int c = 0; c < 8 && cache_init_no; c++) begin
        init_cnt++;
        @(negedge clk_i);
      end
      check("cache_init_no hold cycles", 64'(CacheInitHold), 64'(init_cnt));
    end
  endtask

  // --------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------

  initial begin
    int mark;
    logic [31:0] r;
    logic [7:0] singles [5];
    singles = '{8'h01, 8'h08, 8'h20, 8'h40, 8'h80};
    rst_ni        = 1'b0;
    mispredict_i  = 1'b0;
    fence_i       = 1'b0;
    fence_i_i     = 1'b0;
    sfence_vma_i  = 1'b0;
    fence_t_i     = 1'b0;
    flush_csr_i   = 1'b0;
    ex_valid_i    = 1'b0;
    eret_i        = 1'b0;
    halt_csr_i    = 1'b0;
    time_irq_i    = 1'b0;
    priv_lvl_i    = PRIV_LVL_M;
    pad_src_sel_i = 1'b0;
    fence_t_pad_i = '0;
    boot_addr_i   = Vlen'(64'h0000_0000_8000_0000);
    pc_commit_i   = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    mark = n_fail;
    @(negedge clk_i);
    check("flush strobes", 64'(0), 64'(strobes));
    check("flush_dcache_o", 64'(0), 64'(flush_dcache_o));
    check("halt_o", 64'(0), 64'(halt_o));
    check("stall_cache_o", 64'(0), 64'(stall_cache_o));
    check("rst_uarch_no", 64'(1), 64'(rst_uarch_no));
    check("cache_init_no", 64'(0), 64'(cache_init_no));
    check("rst_addr_o", 64'(boot_addr_i), 64'(rst_addr_o));
    report_test("reset values", mark);

    mark = n_fail;
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      apply_and_check(singles[int'(r[31:16]) % 5]);
    end
    // halt_o follows the CSR halt request while no flush is pending
    for (int i = 0; i < 8; i++) begin
      r = rand32();
      @(posedge clk_i);
      halt_csr_i <= r[31];
      @(negedge clk_i);
      check("halt_o", 64'(r[31]), 64'(halt_o));
    end
    @(posedge clk_i);
    halt_csr_i <= 1'b0;
    report_test("1 single events", mark);

    mark = n_fail;
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      apply_and_check((r[31:24] & 8'h29) | ((r[23:22] == 2'b00) ? 8'h40 : {r[23:22], 6'b0}));
      check("set_pc_commit_o", 64'(0), 64'(set_pc_commit_o));
      check("flush_bp_o", 64'(1), 64'(flush_bp_o));
    end
    report_test("2 exception overrides", mark);

    mark = n_fail;
    for (int i = 0; i < 6 && !timed_out; i++) begin
      r = rand32();
      fence_seq(r[31] ? 8'h04 : 8'h02);
    end
    report_test("3 fence data cache flush", mark);

    mark = n_fail;
    for (int i = 0; i < 2 && !timed_out; i++) fence_t_seq(1'b0);
    report_test("4 fence.t timer pad", mark);

    mark = n_fail;
    for (int i = 0; i < 2 && !timed_out; i++) fence_t_seq(1'b1);
    report_test("5 fence.t user exit pad", mark);

    if (timed_out) $display("Run stopped early after a timeout");
    $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/flush_ctrl_properties.sv ====
// Concurrent checks bound into the sequencer and the flush decoder
// Inputs that an instance does not use are tied off to quiet values

`timescale 1ns/1ps

module flush_ctrl_properties (
  input logic       clk_i,
  input logic       rst_ni,
  input logic [2:0] state_q,
  input logic       rst_uarch_no,
  input logic       stall_cache_o,
  input logic       flush_dcache_o,
  input logic       flush_dcache_ack_i
);

  import ctrl_types_pkg::*;

  // Micro-reset only while the caches are stalled
  assert property (@(posedge clk_i) disable iff (!rst_ni) !rst_uarch_no |-> stall_cache_o)
    else $error("rst_uarch_no low without stall_cache_o");

  // Flush request is a level, only the acknowledge drops it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_dcache_o && !flush_dcache_ack_i |=> flush_dcache_o)
    else $error("flush_dcache_o dropped before the acknowledge");

  // Encoding stays within the defined states
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, FLUSH_DCACHE, DRAIN_REQS, PAD, RST_UARCH})
    else $error("Sequencer state %0h out of range", state_q);

endmodule

bind fence_t_fsm flush_ctrl_properties fsm_props_i (
  .clk_i, .rst_ni, .state_q, .rst_uarch_no, .stall_cache_o,
  .flush_dcache_o     (1'b0),
  .flush_dcache_ack_i (flush_dcache_ack_i)
);

bind flush_decode flush_ctrl_properties decode_props_i (
  .clk_i, .rst_ni,
  .state_q       (3'd0),
  .rst_uarch_no  (1'b1),
  .stall_cache_o (1'b1),
  .flush_dcache_o, .flush_dcache_ack_i
);

// ==== verilog/flush_ctrl_top.sv ====
// Flush and fence controller of the in-order core
// All event inputs are single-cycle strobes without back-pressure

`timescale 1ns/1ps

module flush_ctrl_top #(
  parameter int                         Vlen       = ctrl_cfg_pkg::VlenDefault,
  parameter ctrl_cfg_pkg::dcache_type_e DcacheType = ctrl_cfg_pkg::DCACHE_WB
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              mispredict_i,
  input  logic                              fence_i,
  input  logic                              fence_i_i,
  input  logic                              sfence_vma_i,
  input  logic                              fence_t_i,
  input  logic                              flush_csr_i,
  input  logic                              ex_valid_i,
  input  logic                              eret_i,
  input  logic                              halt_csr_i,
  input  logic                              flush_dcache_ack_i,
  input  logic                              cache_busy_i,
  input  logic                              time_irq_i,
  input  ctrl_types_pkg::priv_lvl_e         priv_lvl_i,
  input  logic                              pad_src_sel_i,
  input  logic [ctrl_cfg_pkg::PadWidth-1:0] fence_t_pad_i,
  input  logic [Vlen-1:0]                   boot_addr_i,
  input  logic [Vlen-1:0]                   pc_commit_i,
  output logic                              set_pc_commit_o,
  output logic                              flush_if_o,
  output logic                              flush_unissued_o,
  output logic                              flush_id_o,
  output logic                              flush_ex_o,
  output logic                              flush_bp_o,
  output logic                              flush_icache_o,
  output logic                              flush_tlb_o,
  output logic                              flush_dcache_o,
  output logic                              halt_o,
  output logic                              stall_cache_o,
  output logic                              rst_uarch_no,
  output logic                              cache_init_no,
  output logic [Vlen-1:0]                   rst_addr_o,
  output logic [ctrl_cfg_pkg::PadWidth-1:0] fence_t_ceil_o
);

  import ctrl_cfg_pkg::*;
  import ctrl_types_pkg::*;

  localparam int DrainWidth = $clog2(DrainCycles);

  // Sequencer not idle, holds the core in halt
  logic fence_t_busy;

  // Drain timer and pad timer buses
  cnt_if #(.Width(DrainWidth)) drain_cnt_bus ();
  cnt_if #(.Width(PadWidth))   pad_cnt_bus ();

  flush_decode #(
    .DcacheType(DcacheType)
  ) flush_decode_i (
    .clk_i, .rst_ni, .mispredict_i, .fence_i, .fence_i_i, .sfence_vma_i,
    .fence_t_i, .flush_csr_i, .ex_valid_i, .eret_i, .halt_csr_i,
    .flush_dcache_ack_i,
    .fence_t_busy_i (fence_t_busy),
    .set_pc_commit_o, .flush_if_o, .flush_unissued_o, .flush_id_o,
    .flush_ex_o, .flush_bp_o, .flush_icache_o, .flush_tlb_o,
    .flush_dcache_o, .halt_o
  );

  fence_t_fsm #(
    .Vlen(Vlen)
  ) fence_t_fsm_i (
    .clk_i, .rst_ni, .fence_t_i, .flush_dcache_ack_i, .cache_busy_i,
    .time_irq_i, .priv_lvl_i, .pad_src_sel_i, .fence_t_pad_i,
    .boot_addr_i, .pc_commit_i,
    .drain_cnt      (drain_cnt_bus),
    .pad_cnt        (pad_cnt_bus),
    .fence_t_busy_o (fence_t_busy),
    .stall_cache_o, .rst_uarch_no, .cache_init_no, .rst_addr_o, .fence_t_ceil_o
  );

  // Counts idle cache cycles while draining
  ctrl_counter #(.Width(DrainWidth)) drain_cnt_i (.clk_i, .rst_ni, .bus(drain_cnt_bus));

  // Counts the timing pad down to zero
  ctrl_counter #(.Width(PadWidth)) pad_cnt_i (.clk_i, .rst_ni, .bus(pad_cnt_bus));

endmodule

// ==== verilog/flush_decode.sv ====
// Flush fan-out from control events, later rules override earlier ones
// Data cache flush is a level held until a one-cycle acknowledge
// Write-through policy flushes the data cache only for fence.t

`timescale 1ns/1ps

module flush_decode #(
  parameter ctrl_cfg_pkg::dcache_type_e DcacheType = ctrl_cfg_pkg::DCACHE_WB
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic mispredict_i,
  input  logic fence_i,
  input  logic fence_i_i,
  input  logic sfence_vma_i,
  input  logic fence_t_i,
  input  logic flush_csr_i,
  input  logic ex_valid_i,
  input  logic eret_i,
  input  logic halt_csr_i,
  input  logic flush_dcache_ack_i,
  input  logic fence_t_busy_i,
  output logic set_pc_commit_o,
  output logic flush_if_o,
  output logic flush_unissued_o,
  output logic flush_id_o,
  output logic flush_ex_o,
  output logic flush_bp_o,
  output logic flush_icache_o,
  output logic flush_tlb_o,
  output logic flush_dcache_o,
  output logic halt_o
);

  import ctrl_cfg_pkg::*;

  localparam logic IsWb = (DcacheType == DCACHE_WB);

  // Data cache flush pending, waiting for the acknowledge
  logic fence_active_d, fence_active_q;
  // Unregistered flush request
  logic flush_dcache;
  // Any event that flushes the whole pipe and restarts at commit
  logic full_flush;

  assign full_flush = fence_i || fence_i_i || sfence_vma_i || flush_csr_i;

  // --------------------------------------------------------------------
  // Event decode
  // --------------------------------------------------------------------

  always_comb begin
    set_pc_commit_o  = 1'b0;
    flush_if_o       = 1'b0;
    flush_unissued_o = 1'b0;
    flush_id_o       = 1'b0;
    flush_ex_o       = 1'b0;
    flush_bp_o       = 1'b0;
    flush_icache_o   = 1'b0;
    flush_tlb_o      = 1'b0;

    // Mispredict kills fetch and anything not yet issued
    if (mispredict_i) begin
      flush_if_o       = 1'b1;
      flush_unissued_o = 1'b1;
    end

    // Fences and CSR side effects restart at the commit PC
    if (full_flush) begin
      set_pc_commit_o  = 1'b1;
      flush_if_o       = 1'b1;
      flush_unissued_o = 1'b1;
      flush_id_o       = 1'b1;
      flush_ex_o       = 1'b1;
    end

    // Instruction memory may have changed
    if (fence_i_i || fence_t_i) flush_icache_o = 1'b1;

    // Translations may have changed
    if (sfence_vma_i) flush_tlb_o = 1'b1;

    // Exception or eret: PC comes from the CSR file, not from commit
    if (ex_valid_i || eret_i) begin
      set_pc_commit_o  = 1'b0;
      flush_if_o       = 1'b1;
      flush_unissued_o = 1'b1;
      flush_id_o       = 1'b1;
      flush_ex_o       = 1'b1;
      // Keeps speculative fetches out after a privilege change
      flush_bp_o       = 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Data cache flush request
  // --------------------------------------------------------------------

  always_comb begin
    fence_active_d = fence_active_q;
    flush_dcache   = 1'b0;

    // Acknowledge ends the pending flush
    if (fence_active_q) begin
      if (flush_dcache_ack_i) begin
        fence_active_d = 1'b0;
      end else begin
        flush_dcache = 1'b1;
      end
    end

    // Write-back cache holds dirty lines a fence must push out
    if (IsWb && (fence_i || fence_i_i)) begin
      flush_dcache   = 1'b1;
      fence_active_d = 1'b1;
    end

    // fence.t empties the cache under either policy
    if (fence_t_i) begin
      flush_dcache   = 1'b1;
      fence_active_d = 1'b1;
    end
  end

  // Stop commit while WFI, a write-back flush or a fence.t is going on
  assign halt_o = halt_csr_i || (IsWb && fence_active_q) || fence_t_busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_o <= 1'b0;
    end else begin
      fence_active_q <= fence_active_d;
      // Registered, the cache sees it one cycle after the event
      flush_dcache_o <= flush_dcache;
    end
  end

endmodule

// ==== verilog/fence_t_fsm.sv ====
// fence.t sequencer: dcache flush, drain, timing pad, micro-reset
// The pad timer runs free and may be loaded before the fence.t arrives
// rst_addr_o holds boot_addr_i from reset until the first fence.t

`timescale 1ns/1ps

module fence_t_fsm #(
  parameter int Vlen = ctrl_cfg_pkg::VlenDefault
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             fence_t_i,
  input  logic                             flush_dcache_ack_i,
  input  logic                             cache_busy_i,
  input  logic                             time_irq_i,
  input  ctrl_types_pkg::priv_lvl_e        priv_lvl_i,
  input  logic                             pad_src_sel_i,
  input  logic [ctrl_cfg_pkg::PadWidth-1:0] fence_t_pad_i,
  input  logic [Vlen-1:0]                  boot_addr_i,
  input  logic [Vlen-1:0]                  pc_commit_i,
  cnt_if.ctrl                              drain_cnt,
  cnt_if.ctrl                              pad_cnt,
  output logic                             fence_t_busy_o,
  output logic                             stall_cache_o,
  output logic                             rst_uarch_no,
  output logic                             cache_init_no,
  output logic [Vlen-1:0]                  rst_addr_o,
  output logic [ctrl_cfg_pkg::PadWidth-1:0] fence_t_ceil_o
);

  import ctrl_types_pkg::*;

  localparam int DrainWidth = $clog2(DrainCycles);
  localparam int RstWidth   = $clog2(RstUarchCycles);

  fence_t_state_e          state_d, state_q;
  logic [RstWidth-1:0]     rst_cnt_d, rst_cnt_q;
  logic [CacheInitHold-1:0] cache_init_q;
  logic [Vlen-1:0]         rst_addr_q;
  logic                    time_irq_q;
  priv_lvl_e               priv_lvl_q;
  logic                    drain_done;
  logic                    load_pad;

  // --------------------------------------------------------------------
  // Counter control
  // --------------------------------------------------------------------

  // Drain timer counts idle cache cycles, only inside DRAIN_REQS
  assign drain_cnt.clear = cache_busy_i | (state_q != DRAIN_REQS);
  assign drain_cnt.en    = (drain_cnt.q != DrainWidth'(DrainCycles - 1));
  assign drain_cnt.load  = 1'b0;
  assign drain_cnt.down  = 1'b0;
  assign drain_cnt.d     = '0;
  // Sixteenth idle cycle in a row
  assign drain_done = !cache_busy_i && (drain_cnt.q == DrainWidth'(DrainCycles - 1));

  // Pad source: leaving U mode, or rising timer interrupt
  assign load_pad = pad_src_sel_i ?
                    ((priv_lvl_q == PRIV_LVL_U) && (priv_lvl_i != PRIV_LVL_U)) :
                    (time_irq_i && !time_irq_q);

  // Pad timer counts down to zero and stops there
  assign pad_cnt.clear = 1'b0;
  assign pad_cnt.en    = |pad_cnt.q;
  assign pad_cnt.load  = load_pad;
  assign pad_cnt.down  = 1'b1;
  assign pad_cnt.d     = fence_t_pad_i;

  // --------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------

  always_comb begin
    state_d        = state_q;
    rst_cnt_d      = rst_cnt_q;
    fence_t_ceil_o = '0;
    unique case (state_q)
      IDLE: begin
        if (fence_t_i) state_d = FLUSH_DCACHE;
      end
      // Wait for the cache to write back its dirty lines
      FLUSH_DCACHE: begin
        if (flush_dcache_ack_i) state_d = DRAIN_REQS;
      end
      // Cache is the only handshaked port, wait until it is quiet
      DRAIN_REQS: begin
        if (drain_done) begin
          state_d        = PAD;
          // Time already used of the pad, zero if the pad has run out
          fence_t_ceil_o = (pad_cnt.q == '0) ? '0 : fence_t_pad_i - pad_cnt.q;
        end
      end
      PAD: begin
        if (pad_cnt.q == '0) state_d = RST_UARCH;
      end
      // Micro-reset pulse, fixed length
      RST_UARCH: begin
        if (rst_cnt_q == RstWidth'(RstUarchCycles - 1)) begin
          rst_cnt_d = '0;
          state_d   = IDLE;
        end else begin
          rst_cnt_d = rst_cnt_q + RstWidth'(1);
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------

  assign fence_t_busy_o = (state_q != IDLE);
  assign stall_cache_o  = (state_q != IDLE);
  assign rst_uarch_no   = (state_q != RST_UARCH);
  // High during the pulse and for CacheInitHold cycles after it
  assign cache_init_no  = (state_q == RST_UARCH) || (|cache_init_q);
  assign rst_addr_o     = rst_addr_q;

  // --------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      rst_cnt_q    <= '0;
      cache_init_q <= '0;
      rst_addr_q   <= boot_addr_i;
      time_irq_q   <= 1'b0;
      priv_lvl_q   <= PRIV_LVL_M;
    end else begin
      state_q      <= state_d;
      rst_cnt_q    <= rst_cnt_d;
      // Shift in the micro-reset phase
      cache_init_q <= {cache_init_q[CacheInitHold-2:0], (state_q == RST_UARCH)};
      // Resume after the fence.t instruction
      if (fence_t_i) rst_addr_q <= pc_commit_i + Vlen'(4);
      time_irq_q   <= time_irq_i;
      priv_lvl_q   <= priv_lvl_i;
    end
  end

endmodule

// ==== verilog/ctrl_counter.sv ====
// Loadable up/down counter, wraps around at both ends
// Clear beats load and load beats enable

`timescale 1ns/1ps

module ctrl_counter #(
  parameter int Width = 4
) (
  input logic clk_i,
  input logic rst_ni,
  cnt_if.cnt  bus
);

  // Count register
  logic [Width-1:0] cnt_q;

  // --------------------------------------------------------------------
  // Count update
  // --------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (bus.clear) begin
      // Restart from zero
      cnt_q <= '0;
    end else if (bus.load) begin
      // Take the new start value
      cnt_q <= bus.d;
    end else if (bus.en) begin
      if (bus.down) begin
        cnt_q <= cnt_q - Width'(1);
      end else begin
        cnt_q <= cnt_q + Width'(1);
      end
    end
  end

  // Current count back to the controller
  assign bus.q = cnt_q;

endmodule

// ==== verilog/cnt_if.sv ====
// Control and value bundle of one counter
// Width must match the Width of the counter that takes the cnt side

`timescale 1ns/1ps

interface cnt_if #(
  parameter int Width = 4
);

  // Control, priority is clear, then load, then enable
  logic             clear;
  logic             en;
  logic             load;
  logic             down;
  // Load value and current count
  logic [Width-1:0] d;
  logic [Width-1:0] q;

  // Controller side drives the controls and reads the count
  modport ctrl (output clear, en, load, down, d, input q);

  // Counter side
  modport cnt (input clear, en, load, down, d, output q);

endinterface

// ==== verilog/ctrl_types_pkg.sv ====
// Shared types of the fence.t sequencer
// Privilege encoding follows the RISC-V privileged spec, H mode is not used

package ctrl_types_pkg;

  // --------------------------------------------------------------------
  // Privilege level
  // --------------------------------------------------------------------

  // Encoding 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // --------------------------------------------------------------------
  // Sequencer states
  // --------------------------------------------------------------------

  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    FLUSH_DCACHE = 3'd1,
    DRAIN_REQS   = 3'd2,
    PAD          = 3'd3,
    RST_UARCH    = 3'd4
  } fence_t_state_e;

  // --------------------------------------------------------------------
  // Cycle counts
  // --------------------------------------------------------------------

  // Idle cycles of the cache before the drain is considered done
  parameter int DrainCycles = 16;
  // Length of the micro-reset pulse
  parameter int RstUarchCycles = 16;
  // Cache init stays off this long after the micro-reset
  parameter int CacheInitHold = 3;

endpackage

// ==== verilog/ctrl_cfg_pkg.sv ====
// Build-time configuration of the flush controller
// Address width and pad width are fixed here and passed down as parameters

package ctrl_cfg_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------

  // Default virtual address width, Sv39 style
  parameter int VlenDefault = 39;

  // Pad counter width, also the width of the pad and ceiling values
  parameter int PadWidth = 32;

  // --------------------------------------------------------------------
  // Data cache write policy
  // --------------------------------------------------------------------

  // Write-through needs no flush on fence or fence.i
  // Write-back must be flushed before memory is coherent again
  typedef enum logic {
    DCACHE_WT = 1'b0,
    DCACHE_WB = 1'b1
  } dcache_type_e;

endpackage
